//--- rtl/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Cache geometry
`define CACHE_SETS 16
`define CACHE_WAYS 8

// Bus widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// Byte offset bits below the index, one word per line
`define CACHE_OFFSET_W 2

`endif

//--- rtl/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	// Derived field widths
	localparam int INDEX_W = $clog2(`CACHE_SETS);
	localparam int WAY_W = $clog2(`CACHE_WAYS);
	localparam int TAG_W = `CACHE_ADDR_W - INDEX_W - `CACHE_OFFSET_W;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_DATA_W-1:0] data_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [WAY_W-1:0] way_t;
	// 0 is the most recently used way
	typedef logic [WAY_W-1:0] age_t;

	// Invalid is all ones
	typedef enum logic [1:0] {
		MODIFIED  = 2'b00,
		EXCLUSIVE = 2'b01,
		SHARED    = 2'b10,
		INVALID   = 2'b11
	} mesi_t;

	typedef enum logic [1:0] {
		OP_READ       = 2'b00,
		OP_WRITE      = 2'b01,
		OP_SNOOP_READ = 2'b10,
		OP_SNOOP_INV  = 2'b11
	} opcode_t;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		UPDATE
	} ctrl_state_t;

	typedef struct packed {
		tag_t tag;
		mesi_t mesi;
		data_t data;
	} line_t;

	// Address field extraction
	function automatic tag_t addr_tag(input addr_t addr);
		return addr[`CACHE_ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(input addr_t addr);
		return addr[`CACHE_OFFSET_W +: INDEX_W];
	endfunction

endpackage

//--- rtl/cache_lookup_if.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

interface cache_lookup_if;

	import cache_pkg::*;

	// Read side, set captured one cycle after rd_index
	index_t rd_index;
	line_t rd_lines [`CACHE_WAYS];
	age_t rd_ages [`CACHE_WAYS];

	// Line write port
	logic wr_en;
	index_t wr_index;
	way_t wr_way;
	line_t wr_line;

	// Age write, whole set at wr_index
	logic age_wr_en;
	age_t new_ages [`CACHE_WAYS];

	modport ctrl (
		output rd_index, wr_en, wr_index, wr_way, wr_line, age_wr_en, new_ages,
		input rd_lines, rd_ages
	);

	modport array (
		input rd_index, wr_en, wr_index, wr_way, wr_line, age_wr_en, new_ages,
		output rd_lines, rd_ages
	);

endinterface

//--- rtl/cache_line_array.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_line_array (
	input logic clk,
	input logic arst_n,
	cache_lookup_if.array lk
);

	import cache_pkg::*;

	// Storage for every set and way
	line_t lines [`CACHE_SETS][`CACHE_WAYS];
	age_t ages [`CACHE_SETS][`CACHE_WAYS];

	// Lines come up Invalid and ages follow the way number
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					lines[s][w] <= '{tag: '0, mesi: INVALID, data: '0};
					ages[s][w] <= age_t'(w);
				end
			end
		end else begin
			if (lk.wr_en) begin
				lines[lk.wr_index][lk.wr_way] <= lk.wr_line;
			end
			if (lk.age_wr_en) begin
				for (int w = 0; w < `CACHE_WAYS; w++) begin
					ages[lk.wr_index][w] <= lk.new_ages[w];
				end
			end
		end
	end

	// Registered read of a whole set
	always_ff @(posedge clk) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			lk.rd_lines[w] <= lines[lk.rd_index][w];
			lk.rd_ages[w] <= ages[lk.rd_index][w];
		end
	end

	// Write target must be a real way of a real set
	a_wr_range: assert property (
		@(posedge clk) disable iff (!arst_n)
		(lk.wr_en || lk.age_wr_en) |->
			(int'(lk.wr_way) < `CACHE_WAYS) && (int'(lk.wr_index) < `CACHE_SETS)
	) else $error("cache_line_array: write outside the array");

endmodule

//--- rtl/cache_lru.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_lru (
	input logic [`CACHE_WAYS-1:0] valid,
	input cache_pkg::age_t ages [`CACHE_WAYS],
	input cache_pkg::way_t access_way,
	output cache_pkg::way_t victim_way,
	output cache_pkg::age_t new_ages [`CACHE_WAYS]
);

	import cache_pkg::*;

	logic found_invalid;
	way_t invalid_way;
	way_t oldest_way;
	age_t oldest_age;
	age_t access_age;

	// Lowest Invalid way, scanning down so the lowest wins
	always_comb begin
		found_invalid = 1'b0;
		invalid_way = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid[w]) begin
				found_invalid = 1'b1;
				invalid_way = way_t'(w);
			end
		end
	end

	// Oldest way by maximal age
	always_comb begin
		oldest_way = '0;
		oldest_age = ages[0];
		for (int w = 1; w < `CACHE_WAYS; w++) begin
			if (ages[w] > oldest_age) begin
				oldest_age = ages[w];
				oldest_way = way_t'(w);
			end
		end
	end

	assign victim_way = found_invalid ? invalid_way : oldest_way;

	// Accessed way becomes youngest, younger ways age by one
	assign access_age = ages[access_way];

	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (way_t'(w) == access_way) begin
				new_ages[w] = '0;
			end else if (ages[w] < access_age) begin
				new_ages[w] = ages[w] + age_t'(1);
			end else begin
				new_ages[w] = ages[w];
			end
		end
	end

endmodule

//--- rtl/cache_controller.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_controller (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input cache_pkg::opcode_t cmd_op,
	input cache_pkg::addr_t cmd_addr,
	input cache_pkg::data_t cmd_data,
	cache_lookup_if.ctrl lk,
	input cache_pkg::way_t victim_way,
	output cache_pkg::way_t access_way,
	output logic resp_valid,
	output logic resp_hit,
	output cache_pkg::data_t resp_data,
	output logic wb_valid,
	output cache_pkg::addr_t wb_addr,
	output cache_pkg::data_t wb_data
);

	import cache_pkg::*;

	ctrl_state_t state;

	// Command held for the whole transaction
	opcode_t op_q;
	addr_t addr_q;
	data_t data_q;
	tag_t tag_q;
	index_t index_q;

	logic [`CACHE_WAYS-1:0] way_hit;
	logic hit;
	way_t hit_way;
	line_t sel_line;
	logic cpu_op;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_valid) begin
						state <= LOOKUP;
					end
				end
				LOOKUP: state <= UPDATE;
				UPDATE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid) begin
			op_q <= cmd_op;
			addr_q <= cmd_addr;
			data_q <= cmd_data;
		end
	end

	assign tag_q = addr_tag(addr_q);
	assign index_q = addr_index(addr_q);

	// Set read is issued from the held address
	assign lk.rd_index = index_q;

	// Tag compare across all ways, lowest matching way wins
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			way_hit[w] = (lk.rd_lines[w].mesi != INVALID) && (lk.rd_lines[w].tag == tag_q);
		end
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit = |way_hit;
	assign cpu_op = (op_q == OP_READ) || (op_q == OP_WRITE);

	// Hit way on a hit, otherwise the allocation victim
	assign access_way = hit ? hit_way : victim_way;
	assign sel_line = lk.rd_lines[access_way];

	// Evicted line address rebuilt from its tag and the set
	assign wb_addr = {sel_line.tag, index_q, {`CACHE_OFFSET_W{1'b0}}};
	assign wb_data = sel_line.data;

	// MESI update and response, all decided in UPDATE
	always_comb begin
		lk.wr_en = 1'b0;
		lk.wr_index = index_q;
		lk.wr_way = access_way;
		lk.wr_line = sel_line;
		lk.age_wr_en = 1'b0;
		resp_valid = 1'b0;
		resp_hit = 1'b0;
		resp_data = '0;
		wb_valid = 1'b0;
		if (state == UPDATE) begin
			resp_valid = 1'b1;
			resp_hit = hit;
			// Snoops leave the ages alone
			lk.age_wr_en = cpu_op;
			case (op_q)
				OP_READ: begin
					if (hit) begin
						resp_data = sel_line.data;
					end else begin
						lk.wr_en = 1'b1;
						lk.wr_line = '{tag: tag_q, mesi: EXCLUSIVE, data: data_q};
						resp_data = data_q;
						wb_valid = (sel_line.mesi == MODIFIED);
					end
				end
				OP_WRITE: begin
					lk.wr_en = 1'b1;
					lk.wr_line = '{tag: tag_q, mesi: MODIFIED, data: data_q};
					wb_valid = !hit && (sel_line.mesi == MODIFIED);
				end
				OP_SNOOP_READ: begin
					if (hit) begin
						resp_data = sel_line.data;
						// Shared lines need no write
						if (sel_line.mesi == MODIFIED || sel_line.mesi == EXCLUSIVE) begin
							lk.wr_en = 1'b1;
							lk.wr_line.mesi = SHARED;
						end
					end
				end
				OP_SNOOP_INV: begin
					if (hit) begin
						lk.wr_en = 1'b1;
						lk.wr_line.mesi = INVALID;
					end
				end
				default: begin
					lk.wr_en = 1'b0;
				end
			endcase
		end
	end

	// Only one command in flight
	a_no_cmd_busy: assert property (
		@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> state == IDLE
	) else $error("cache_controller: command strobe while busy");

	a_wb_with_resp: assert property (
		@(posedge clk) disable iff (!arst_n)
		wb_valid |-> resp_valid
	) else $error("cache_controller: write-back without response");

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top (
	input logic clk,
	input logic arst_n,
	input logic cmd_valid,
	input cache_pkg::opcode_t cmd_op,
	input cache_pkg::addr_t cmd_addr,
	input cache_pkg::data_t cmd_data,
	output logic resp_valid,
	output logic resp_hit,
	output cache_pkg::data_t resp_data,
	output logic wb_valid,
	output cache_pkg::addr_t wb_addr,
	output cache_pkg::data_t wb_data
);

	import cache_pkg::*;

	logic [`CACHE_WAYS-1:0] line_valid;
	way_t victim_way;
	way_t access_way;

	cache_lookup_if lk ();

	// Valid flags of the set just read
	always_comb begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			line_valid[w] = (lk.rd_lines[w].mesi != INVALID);
		end
	end

	cache_line_array line_array_i (
		.clk(clk),
		.arst_n(arst_n),
		.lk(lk.array)
	);

	// Victim choice and age update for the current set
	cache_lru lru_i (
		.valid(line_valid),
		.ages(lk.rd_ages),
		.access_way(access_way),
		.victim_way(victim_way),
		.new_ages(lk.new_ages)
	);

	cache_controller controller_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.lk(lk.ctrl),
		.victim_way(victim_way),
		.access_way(access_way),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

endmodule

//--- verification/cache_ref_model.svh
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

// Behavioral cache state, one entry per set and way
tag_t m_tag [`CACHE_SETS][`CACHE_WAYS];
mesi_t m_mesi [`CACHE_SETS][`CACHE_WAYS];
data_t m_data [`CACHE_SETS][`CACHE_WAYS];
int m_age [`CACHE_SETS][`CACHE_WAYS];

function automatic void model_reset();
	for (int s = 0; s < `CACHE_SETS; s++) begin
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			m_tag[s][w] = '0;
			m_mesi[s][w] = INVALID;
			m_data[s][w] = '0;
			m_age[s][w] = w;
		end
	end
endfunction

// First Invalid way, else the oldest one
function automatic int pick_victim(input int set);
	int oldest;
	oldest = 0;
	for (int w = 0; w < `CACHE_WAYS; w++) begin
		if (m_mesi[set][w] == INVALID) begin
			return w;
		end
	end
	for (int w = 1; w < `CACHE_WAYS; w++) begin
		if (m_age[set][w] > m_age[set][oldest]) begin
			oldest = w;
		end
	end
	return oldest;
endfunction

// Accessed way turns youngest
function automatic void touch_way(input int set, input int way);
	int old_age;
	old_age = m_age[set][way];
	for (int w = 0; w < `CACHE_WAYS; w++) begin
		if (w == way) begin
			m_age[set][w] = 0;
		end else if (m_age[set][w] < old_age) begin
			m_age[set][w] = m_age[set][w] + 1;
		end
	end
endfunction

task automatic model_apply(input opcode_t op, input addr_t addr, input data_t data,
		output logic hit, output data_t rdata, output logic wb,
		output addr_t wba, output data_t wbd);
	int set;
	int way;
	tag_t tag;
	set = int'((addr >> `CACHE_OFFSET_W) % `CACHE_SETS);
	tag = tag_t'(addr >> (`CACHE_OFFSET_W + INDEX_W));
	way = -1;
	rdata = '0;
	wb = 1'b0;
	wba = '0;
	wbd = '0;
	for (int w = 0; w < `CACHE_WAYS; w++) begin
		if (way < 0 && m_mesi[set][w] != INVALID && m_tag[set][w] == tag) begin
			way = w;
		end
	end
	hit = (way >= 0);
	if (!hit) begin
		way = pick_victim(set);
	end
	// Allocating CPU ops may push out a dirty line
	if (!hit && (op == OP_READ || op == OP_WRITE) && m_mesi[set][way] == MODIFIED) begin
		wb = 1'b1;
		wba = (addr_t'(m_tag[set][way]) << (INDEX_W + `CACHE_OFFSET_W))
			| (addr_t'(set) << `CACHE_OFFSET_W);
		wbd = m_data[set][way];
	end
	case (op)
		OP_READ: begin
			if (hit) begin
				rdata = m_data[set][way];
			end else begin
				m_tag[set][way] = tag;
				m_mesi[set][way] = EXCLUSIVE;
				m_data[set][way] = data;
				rdata = data;
			end
		end
		OP_WRITE: begin
			m_tag[set][way] = tag;
			m_mesi[set][way] = MODIFIED;
			m_data[set][way] = data;
		end
		OP_SNOOP_READ: begin
			if (hit) begin
				rdata = m_data[set][way];
				m_mesi[set][way] = SHARED;
			end
		end
		default: begin
			if (hit) begin
				m_mesi[set][way] = INVALID;
			end
		end
	endcase
	if (op == OP_READ || op == OP_WRITE) begin
		touch_way(set, way);
	end
endtask

`endif

//--- verification/cache_tb.sv
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_tb;

	import cache_pkg::*;

	`include "cache_ref_model.svh"

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int RESP_TIMEOUT = 10;
	localparam int RANDOM_CMDS = 400;
	localparam int SEED = 64138;

	logic clk;
	logic arst_n;
	logic cmd_valid;
	opcode_t cmd_op;
	addr_t cmd_addr;
	data_t cmd_data;
	logic resp_valid;
	logic resp_hit;
	data_t resp_data;
	logic wb_valid;
	addr_t wb_addr;
	data_t wb_data;

	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;

	// Outputs seen with the last response
	logic got_hit;
	data_t got_data;
	logic got_wb;
	addr_t got_wba;
	data_t got_wbd;

	cache_top dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_addr(cmd_addr),
		.cmd_data(cmd_data),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_data(resp_data),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
		end
	endtask

	function automatic addr_t make_addr(input int tag, input int set);
		return (addr_t'(tag) << (INDEX_W + `CACHE_OFFSET_W)) | (addr_t'(set) << `CACHE_OFFSET_W);
	endfunction

	task automatic start_test();
		test_start_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == test_start_errors) begin
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d mismatches", name, errors - test_start_errors);
		end
	endtask

	// One command through the DUT, checked against the model
	task automatic send_cmd(input string name, input opcode_t op, input addr_t addr,
			input data_t data);
		logic exp_hit;
		data_t exp_data;
		logic exp_wb;
		addr_t exp_wba;
		data_t exp_wbd;
		int cycles;
		model_apply(op, addr, data, exp_hit, exp_data, exp_wb, exp_wba, exp_wbd);
		@(posedge clk);
		#1;
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_addr = addr;
		cmd_data = data;
		@(posedge clk);
		#1;
		cmd_valid = 1'b0;
		cycles = 0;
		while (!resp_valid && cycles < RESP_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!resp_valid) begin
			$display("Timeout: no response within %0d cycles for %s", RESP_TIMEOUT, name);
			$display("=== FAIL ===");
			$finish;
		end else begin
			got_hit = resp_hit;
			got_data = resp_data;
			got_wb = wb_valid;
			got_wba = wb_addr;
			got_wbd = wb_data;
			check_value({name, " resp_hit"}, exp_hit, resp_hit);
			check_value({name, " resp_data"}, exp_data, resp_data);
			check_value({name, " wb_valid"}, exp_wb, wb_valid);
			if (exp_wb && wb_valid) begin
				check_value({name, " wb_addr"}, exp_wba, wb_addr);
				check_value({name, " wb_data"}, exp_wbd, wb_data);
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = OP_READ;
		cmd_addr = '0;
		cmd_data = '0;
		model_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;

		start_test();
		send_cmd("t1 write", OP_WRITE, make_addr(3, 1), 32'hcafe_0001);
		send_cmd("t1 read", OP_READ, make_addr(3, 1), 32'h0);
		check_value("t1 read hit", 1, got_hit);
		check_value("t1 read data", 32'hcafe_0001, got_data);
		finish_test("write_then_read");

		start_test();
		send_cmd("t2 miss", OP_READ, make_addr(7, 2), 32'h1234_5678);
		check_value("t2 miss hit", 0, got_hit);
		check_value("t2 miss data", 32'h1234_5678, got_data);
		send_cmd("t2 hit", OP_READ, make_addr(7, 2), 32'hdead_beef);
		check_value("t2 hit hit", 1, got_hit);
		check_value("t2 hit data", 32'h1234_5678, got_data);
		finish_test("read_miss_fill");

		// Nine tags in set 5, the first one is the LRU victim
		start_test();
		for (int t = 0; t < 9; t++) begin
			send_cmd($sformatf("t3 write %0d", t), OP_WRITE, make_addr(t + 1, 5),
				32'h5500_0000 + t);
		end
		check_value("t3 wb_valid", 1, got_wb);
		check_value("t3 wb_addr", make_addr(1, 5), got_wba);
		check_value("t3 wb_data", 32'h5500_0000, got_wbd);
		finish_test("lru_eviction");

		start_test();
		send_cmd("t4 write", OP_WRITE, make_addr(20, 9), 32'h9999_0000);
		send_cmd("t4 snoop read", OP_SNOOP_READ, make_addr(20, 9), 32'h0);
		check_value("t4 snoop data", 32'h9999_0000, got_data);
		for (int t = 0; t < 8; t++) begin
			send_cmd($sformatf("t4 fill %0d", t), OP_WRITE, make_addr(30 + t, 9), t);
		end
		check_value("t4 shared evict wb_valid", 0, got_wb);
		send_cmd("t4 write inv", OP_WRITE, make_addr(40, 11), 32'h4040_4040);
		send_cmd("t4 snoop inv", OP_SNOOP_INV, make_addr(40, 11), 32'h0);
		check_value("t4 snoop inv hit", 1, got_hit);
		send_cmd("t4 read after inv", OP_READ, make_addr(40, 11), 32'h0bad_f00d);
		check_value("t4 read after inv hit", 0, got_hit);
		finish_test("snoop_read_invalidate");

		// Twelve tags over four sets keeps the sets conflicting
		start_test();
		for (int i = 0; i < RANDOM_CMDS; i++) begin
			send_cmd($sformatf("t5 cmd %0d", i), opcode_t'($urandom % 4),
				make_addr(int'($urandom % 12), int'($urandom % 4)) | addr_t'($urandom % 4),
				$urandom);
		end
		finish_test("random_sequence");

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+rtl
+incdir+verification
rtl/cache_pkg.sv
rtl/cache_lookup_if.sv
rtl/cache_line_array.sv
rtl/cache_lru.sv
rtl/cache_controller.sv
rtl/cache_top.sv
verification/cache_tb.sv

//--- Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard rtl/*.svh verification/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
